// ==== logic/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// major opcode, inst[31:26]
	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_j       = 6'h02,
		op_jal     = 6'h03,
		op_beq     = 6'h04,
		op_bne     = 6'h05,
		op_addiu   = 6'h09,
		op_slti    = 6'h0a,
		op_sltiu   = 6'h0b,
		op_andi    = 6'h0c,
		op_ori     = 6'h0d,
		op_xori    = 6'h0e,
		op_lui     = 6'h0f,
		op_lb      = 6'h20,
		op_lw      = 6'h23,
		op_lbu     = 6'h24,
		op_sb      = 6'h28,
		op_sw      = 6'h2b
	} opcode_e;

	// special group, inst[5:0]
	typedef enum logic [5:0] {
		fn_jr   = 6'h08,
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_xor  = 6'h26,
		fn_nor  = 6'h27,
		fn_slt  = 6'h2a,
		fn_sltu = 6'h2b
	} funct_e;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor, alu_slt, alu_sltu, alu_lui
	} alu_op_e;

	typedef enum logic [2:0] {
		mem_none, mem_load_word, mem_load_byte, mem_load_byte_u, mem_store_word, mem_store_byte
	} mem_op_e;

	typedef enum logic [1:0] {wb_exe_result, wb_mem_load, wb_link} wb_sel_e;

	typedef enum logic [1:0] {pc_seq, pc_branch, pc_jump, pc_jump_reg} pc_sel_e;

	localparam word_t nop_word = 32'h0000_0000;   // sll $0 pattern, decodes as a bubble
	localparam word_t link_offset = 32'd8;        // past the delay slot
	localparam reg_addr_t reg_link = 5'd31;

endpackage

`default_nettype wire

// ==== logic/mips_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_decoder (
	input  mips_pkg::word_t     inst,
	output mips_pkg::reg_addr_t rs,
	output mips_pkg::reg_addr_t rt,
	output mips_pkg::reg_addr_t dest,
	output logic                reg_we,
	output mips_pkg::alu_op_e   alu_op,
	output logic                use_imm,
	output logic                imm_zero_ext,
	output mips_pkg::mem_op_e   mem_op,
	output mips_pkg::wb_sel_e   wb_sel,
	output logic                branch_ne,
	output logic                is_branch,
	output mips_pkg::pc_sel_e   jump_kind,
	output logic                uses_rs,
	output logic                uses_rt
);

	mips_pkg::opcode_e opcode;
	mips_pkg::funct_e funct;
	mips_pkg::reg_addr_t rd;

	assign opcode = mips_pkg::opcode_e'(inst[31:26]);
	assign funct = mips_pkg::funct_e'(inst[5:0]);
	assign rs = inst[25:21];
	assign rt = inst[20:16];
	assign rd = inst[15:11];

	always_comb begin
		// bubble unless an encoding below matches
		dest = 5'd0;
		reg_we = 1'b0;
		alu_op = mips_pkg::alu_add;
		use_imm = 1'b0;
		imm_zero_ext = 1'b0;
		mem_op = mips_pkg::mem_none;
		wb_sel = mips_pkg::wb_exe_result;
		branch_ne = 1'b0;
		is_branch = 1'b0;
		jump_kind = mips_pkg::pc_seq;
		uses_rs = 1'b0;
		uses_rt = 1'b0;

		case (opcode)
			mips_pkg::op_special: begin
				case (funct)
					mips_pkg::fn_jr: begin
						jump_kind = mips_pkg::pc_jump_reg;
						uses_rs = 1'b1;
					end
					mips_pkg::fn_addu, mips_pkg::fn_subu, mips_pkg::fn_and, mips_pkg::fn_or,
					mips_pkg::fn_xor, mips_pkg::fn_nor, mips_pkg::fn_slt, mips_pkg::fn_sltu: begin
						dest = rd;
						reg_we = rd != 5'd0;   // writes to $0 are dropped here
						uses_rs = 1'b1;
						uses_rt = 1'b1;
						case (funct)
							mips_pkg::fn_subu: alu_op = mips_pkg::alu_sub;
							mips_pkg::fn_and:  alu_op = mips_pkg::alu_and;
							mips_pkg::fn_or:   alu_op = mips_pkg::alu_or;
							mips_pkg::fn_xor:  alu_op = mips_pkg::alu_xor;
							mips_pkg::fn_nor:  alu_op = mips_pkg::alu_nor;
							mips_pkg::fn_slt:  alu_op = mips_pkg::alu_slt;
							mips_pkg::fn_sltu: alu_op = mips_pkg::alu_sltu;
							default:           alu_op = mips_pkg::alu_add;
						endcase
					end
					default: ;
				endcase
			end
			mips_pkg::op_addiu, mips_pkg::op_slti, mips_pkg::op_sltiu, mips_pkg::op_andi,
			mips_pkg::op_ori, mips_pkg::op_xori, mips_pkg::op_lui: begin
				dest = rt;
				reg_we = rt != 5'd0;
				use_imm = 1'b1;
				uses_rs = opcode != mips_pkg::op_lui;   // lui has no register source
				imm_zero_ext = opcode inside {mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori};
				case (opcode)
					mips_pkg::op_slti:  alu_op = mips_pkg::alu_slt;
					mips_pkg::op_sltiu: alu_op = mips_pkg::alu_sltu;
					mips_pkg::op_andi:  alu_op = mips_pkg::alu_and;
					mips_pkg::op_ori:   alu_op = mips_pkg::alu_or;
					mips_pkg::op_xori:  alu_op = mips_pkg::alu_xor;
					mips_pkg::op_lui:   alu_op = mips_pkg::alu_lui;
					default:            alu_op = mips_pkg::alu_add;
				endcase
			end
			mips_pkg::op_lw, mips_pkg::op_lb, mips_pkg::op_lbu: begin
				dest = rt;
				reg_we = rt != 5'd0;
				use_imm = 1'b1;
				uses_rs = 1'b1;
				wb_sel = mips_pkg::wb_mem_load;
				if (opcode == mips_pkg::op_lw)
					mem_op = mips_pkg::mem_load_word;
				else if (opcode == mips_pkg::op_lb)
					mem_op = mips_pkg::mem_load_byte;
				else
					mem_op = mips_pkg::mem_load_byte_u;
			end
			mips_pkg::op_sw, mips_pkg::op_sb: begin
				use_imm = 1'b1;
				uses_rs = 1'b1;
				uses_rt = 1'b1;   // store data
				mem_op = (opcode == mips_pkg::op_sw) ? mips_pkg::mem_store_word
					: mips_pkg::mem_store_byte;
			end
			mips_pkg::op_beq, mips_pkg::op_bne: begin
				is_branch = 1'b1;
				branch_ne = opcode == mips_pkg::op_bne;
				uses_rs = 1'b1;
				uses_rt = 1'b1;
			end
			mips_pkg::op_j: jump_kind = mips_pkg::pc_jump;
			mips_pkg::op_jal: begin
				jump_kind = mips_pkg::pc_jump;
				dest = mips_pkg::reg_link;
				reg_we = 1'b1;
				wb_sel = mips_pkg::wb_link;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file (
	input  logic                clk,
	input  logic                rst,
	input  mips_pkg::reg_addr_t read_a,
	input  mips_pkg::reg_addr_t read_b,
	output mips_pkg::word_t     data_a,
	output mips_pkg::word_t     data_b,
	input  logic                we,
	input  mips_pkg::reg_addr_t write_addr,
	input  mips_pkg::word_t     write_data
);

	mips_pkg::word_t regs [1:31];   // $0 has no storage

	// falling edge write, so decode sees write-back data in the same cycle
	always_ff @(negedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (we && write_addr != 5'd0) begin
			regs[write_addr] <= write_data;
		end
	end

	assign data_a = (read_a == 5'd0) ? '0 : regs[read_a];
	assign data_b = (read_b == 5'd0) ? '0 : regs[read_b];

endmodule

`default_nettype wire

// ==== logic/operand_forward.sv ====
`timescale 1ns/10ps
`default_nettype none

module operand_forward (
	input  mips_pkg::reg_addr_t rs,
	input  mips_pkg::reg_addr_t rt,
	input  logic                uses_rs,
	input  logic                uses_rt,
	input  mips_pkg::word_t     file_a,
	input  mips_pkg::word_t     file_b,
	input  mips_pkg::reg_addr_t exe_dest,
	input  logic                exe_we,
	input  logic                exe_is_load,
	input  mips_pkg::word_t     exe_value,
	input  mips_pkg::reg_addr_t mem_dest,
	input  logic                mem_we,
	input  mips_pkg::word_t     mem_value,
	output mips_pkg::word_t     op_a,
	output mips_pkg::word_t     op_b,
	output logic                stall
);

	// youngest producer wins
	function automatic mips_pkg::word_t pick(input mips_pkg::reg_addr_t src,
		input mips_pkg::word_t file_value);
		if (src == 5'd0)
			return file_value;
		if (exe_we && exe_dest == src)
			return exe_value;
		if (mem_we && mem_dest == src)
			return mem_value;
		return file_value;
	endfunction

	assign op_a = pick(rs, file_a);
	assign op_b = pick(rt, file_b);

	// load data only exists one stage later, hold decode one cycle
	assign stall = exe_is_load && exe_we && exe_dest != 5'd0
		&& ((uses_rs && exe_dest == rs) || (uses_rt && exe_dest == rt));

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
	input  mips_pkg::word_t   a,
	input  mips_pkg::word_t   b,
	input  mips_pkg::alu_op_e op,
	output mips_pkg::word_t   result
);

	logic lt_signed;
	logic lt_unsigned;

	assign lt_signed = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (op)
			mips_pkg::alu_add:  result = a + b;   // wraps, no trap
			mips_pkg::alu_sub:  result = a - b;
			mips_pkg::alu_and:  result = a & b;
			mips_pkg::alu_or:   result = a | b;
			mips_pkg::alu_xor:  result = a ^ b;
			mips_pkg::alu_nor:  result = ~(a | b);
			mips_pkg::alu_slt:  result = {31'b0, lt_signed};
			mips_pkg::alu_sltu: result = {31'b0, lt_unsigned};
			mips_pkg::alu_lui:  result = b << 16;
			default:            result = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/mem_lanes.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_lanes (
	input  mips_pkg::mem_op_e op,
	input  mips_pkg::word_t   addr,
	input  mips_pkg::word_t   store_value,
	input  mips_pkg::word_t   read_word,
	output mips_pkg::word_t   word_addr,
	output mips_pkg::word_t   lane_data,
	output logic [3:0]        byte_we,
	output logic              read_strobe,
	output mips_pkg::word_t   load_value
);

	logic [7:0] load_byte;

	assign word_addr = {addr[31:2], 2'b00};
	assign read_strobe = op inside {mips_pkg::mem_load_word, mips_pkg::mem_load_byte,
		mips_pkg::mem_load_byte_u};

	// store side, lane 0 is bits 7:0
	always_comb begin
		lane_data = store_value;
		byte_we = 4'b0000;
		case (op)
			mips_pkg::mem_store_word: begin
				if (addr[1:0] == 2'b00)
					byte_we = 4'b1111;   // unaligned sw is dropped
			end
			mips_pkg::mem_store_byte: begin
				lane_data = store_value << {addr[1:0], 3'b000};
				byte_we = 4'b0001 << addr[1:0];
			end
			default: ;
		endcase
	end

	// load side
	always_comb begin
		case (addr[1:0])
			2'b00: load_byte = read_word[7:0];
			2'b01: load_byte = read_word[15:8];
			2'b10: load_byte = read_word[23:16];
			default: load_byte = read_word[31:24];
		endcase
	end

	always_comb begin
		case (op)
			mips_pkg::mem_load_byte:   load_value = {{24{load_byte[7]}}, load_byte};
			mips_pkg::mem_load_byte_u: load_value = {24'b0, load_byte};
			default:                   load_value = read_word;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/pipeline_cpu.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipeline_cpu #(
	parameter mips_pkg::word_t reset_pc = 32'h0000_0000
) (
	input  logic            clk,
	input  logic            rst,
	output mips_pkg::word_t inst_addr,
	input  mips_pkg::word_t inst_data,
	output mips_pkg::word_t mem_addr,
	output mips_pkg::word_t mem_data,
	output logic [3:0]      mem_we,
	output logic            mem_rd,
	input  mips_pkg::word_t mem_data_in
);

	////////////////////////////////////////////////////////////
	// fetch
	mips_pkg::word_t pc, pc_next, pc_plus4;
	mips_pkg::pc_sel_e pc_sel;
	logic stall;

	assign inst_addr = pc;
	assign pc_plus4 = pc + 32'd4;

	always_ff @(posedge clk) begin
		if (rst)
			pc <= reset_pc;
		else if (!stall)
			pc <= pc_next;
	end

	mips_pkg::word_t id_inst, id_pc;

	always_ff @(posedge clk) begin
		if (rst)
			id_inst <= mips_pkg::nop_word;
		else if (!stall)
			id_inst <= inst_data;
	end

	always_ff @(posedge clk) begin
		if (!stall)
			id_pc <= pc;
	end

	////////////////////////////////////////////////////////////
	// decode, branch resolve
	mips_pkg::reg_addr_t dec_rs, dec_rt, dec_dest;
	logic dec_reg_we, dec_use_imm, dec_imm_zero_ext, dec_branch_ne, dec_is_branch;
	logic dec_uses_rs, dec_uses_rt;
	mips_pkg::alu_op_e dec_alu_op;
	mips_pkg::mem_op_e dec_mem_op;
	mips_pkg::wb_sel_e dec_wb_sel;
	mips_pkg::pc_sel_e dec_jump_kind;
	mips_pkg::word_t file_a, file_b, op_a, op_b, imm_ext, id_pc_plus4;

	mips_decoder decoder (
		.inst(id_inst), .rs(dec_rs), .rt(dec_rt), .dest(dec_dest), .reg_we(dec_reg_we),
		.alu_op(dec_alu_op), .use_imm(dec_use_imm), .imm_zero_ext(dec_imm_zero_ext),
		.mem_op(dec_mem_op), .wb_sel(dec_wb_sel), .branch_ne(dec_branch_ne),
		.is_branch(dec_is_branch), .jump_kind(dec_jump_kind), .uses_rs(dec_uses_rs),
		.uses_rt(dec_uses_rt)
	);

	// write-back stage signals, driven further down
	logic wb_we;
	mips_pkg::reg_addr_t wb_dest;
	mips_pkg::word_t wb_data;

	reg_file regs (
		.clk(clk), .rst(rst), .read_a(dec_rs), .read_b(dec_rt), .data_a(file_a),
		.data_b(file_b), .we(wb_we), .write_addr(wb_dest), .write_data(wb_data)
	);

	assign imm_ext = dec_imm_zero_ext ? {16'b0, id_inst[15:0]}
		: {{16{id_inst[15]}}, id_inst[15:0]};
	assign id_pc_plus4 = id_pc + 32'd4;

	always_comb begin
		pc_sel = dec_jump_kind;
		if (dec_is_branch && ((op_a == op_b) != dec_branch_ne))
			pc_sel = mips_pkg::pc_branch;
	end

	always_comb begin
		case (pc_sel)
			mips_pkg::pc_branch:   pc_next = id_pc_plus4 + {imm_ext[29:0], 2'b00};
			mips_pkg::pc_jump:     pc_next = {id_pc_plus4[31:28], id_inst[25:0], 2'b00};
			mips_pkg::pc_jump_reg: pc_next = op_a;
			default:               pc_next = pc_plus4;
		endcase
	end

	////////////////////////////////////////////////////////////
	// execute
	logic ex_reg_we;
	mips_pkg::mem_op_e ex_mem_op;
	mips_pkg::wb_sel_e ex_wb_sel;
	mips_pkg::alu_op_e ex_alu_op;
	mips_pkg::reg_addr_t ex_dest;
	mips_pkg::word_t ex_a, ex_b, ex_store, ex_pc, ex_alu_result, ex_value;

	always_ff @(posedge clk) begin
		if (rst || stall) begin   // bubble into execute
			ex_reg_we <= 1'b0;
			ex_mem_op <= mips_pkg::mem_none;
			ex_wb_sel <= mips_pkg::wb_exe_result;
		end else begin
			ex_reg_we <= dec_reg_we;
			ex_mem_op <= dec_mem_op;
			ex_wb_sel <= dec_wb_sel;
		end
	end

	always_ff @(posedge clk) begin
		ex_alu_op <= dec_alu_op;
		ex_dest <= dec_dest;
		ex_a <= op_a;
		ex_b <= dec_use_imm ? imm_ext : op_b;
		ex_store <= op_b;
		ex_pc <= id_pc;
	end

	alu exe_alu (.a(ex_a), .b(ex_b), .op(ex_alu_op), .result(ex_alu_result));

	assign ex_value = (ex_wb_sel == mips_pkg::wb_link) ? ex_pc + mips_pkg::link_offset
		: ex_alu_result;

	////////////////////////////////////////////////////////////
	// memory
	logic mem_reg_we;
	mips_pkg::mem_op_e mem_mem_op;
	mips_pkg::wb_sel_e mem_wb_sel;
	mips_pkg::reg_addr_t mem_dest;
	mips_pkg::word_t mem_result, mem_store, mem_load_value, mem_value;

	always_ff @(posedge clk) begin
		if (rst) begin
			mem_reg_we <= 1'b0;
			mem_mem_op <= mips_pkg::mem_none;
			mem_wb_sel <= mips_pkg::wb_exe_result;
		end else begin
			mem_reg_we <= ex_reg_we;
			mem_mem_op <= ex_mem_op;
			mem_wb_sel <= ex_wb_sel;
		end
	end

	always_ff @(posedge clk) begin
		mem_dest <= ex_dest;
		mem_result <= ex_value;   // address for loads and stores
		mem_store <= ex_store;
	end

	mem_lanes lanes (
		.op(mem_mem_op), .addr(mem_result), .store_value(mem_store),
		.read_word(mem_data_in), .word_addr(mem_addr), .lane_data(mem_data),
		.byte_we(mem_we), .read_strobe(mem_rd), .load_value(mem_load_value)
	);

	assign mem_value = (mem_wb_sel == mips_pkg::wb_mem_load) ? mem_load_value : mem_result;

	operand_forward fwd (
		.rs(dec_rs), .rt(dec_rt), .uses_rs(dec_uses_rs), .uses_rt(dec_uses_rt),
		.file_a(file_a), .file_b(file_b), .exe_dest(ex_dest), .exe_we(ex_reg_we),
		.exe_is_load(ex_wb_sel == mips_pkg::wb_mem_load), .exe_value(ex_value),
		.mem_dest(mem_dest), .mem_we(mem_reg_we), .mem_value(mem_value),
		.op_a(op_a), .op_b(op_b), .stall(stall)
	);

	////////////////////////////////////////////////////////////
	// write-back
	always_ff @(posedge clk) begin
		if (rst)
			wb_we <= 1'b0;
		else
			wb_we <= mem_reg_we;
	end

	always_ff @(posedge clk) begin
		wb_dest <= mem_dest;
		wb_data <= mem_value;
	end

endmodule

`default_nettype wire

// ==== test/cpu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_tb;

	localparam int reset_cycles = 16;
	localparam int clk_period = 10;
	localparam int max_stores = 64;
	localparam string cases_path = "test/cpu_cases.txt";

	logic clk;
	logic rst;
	mips_pkg::word_t inst_addr;
	mips_pkg::word_t inst_data;
	mips_pkg::word_t mem_addr;
	mips_pkg::word_t mem_data;
	mips_pkg::word_t mem_data_in;
	logic [3:0] mem_we;
	logic mem_rd;

	mips_pkg::word_t imem [0:255];
	mips_pkg::word_t dmem [0:1023];   // 4 KB data space

	string exp_name [0:max_stores-1];
	mips_pkg::word_t exp_addr [0:max_stores-1];
	mips_pkg::word_t exp_data [0:max_stores-1];
	logic [3:0] exp_we [0:max_stores-1];
	int n_prog;
	int n_exp;
	int n_seen;
	int reset_edges;
	logic loaded;
	logic self_loop;

	pipeline_cpu #(.reset_pc(32'h0000_0000)) uut (
		.clk(clk), .rst(rst), .inst_addr(inst_addr), .inst_data(inst_data),
		.mem_addr(mem_addr), .mem_data(mem_data), .mem_we(mem_we), .mem_rd(mem_rd),
		.mem_data_in(mem_data_in)
	);

	assign inst_data = imem[inst_addr[9:2]];
	assign mem_data_in = dmem[mem_addr[11:2]];
	// a j to its own address marks the end of the program
	assign self_loop = inst_data[31:26] == 6'h02
		&& {inst_addr[31:28], inst_data[25:0], 2'b00} == inst_addr;

	////////////////////////////////////////////////////////////
	// helpers
	task automatic fail_run(input string reason);
		$display("=== FAIL ===");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_value(input string test_name, input string field,
		input mips_pkg::word_t expected, input mips_pkg::word_t actual);
		if (expected !== actual) begin
			$display("Error: %s %s expected %h actual %h", test_name, field, expected, actual);
			fail_run("value mismatch");
		end
	endtask

	function automatic mips_pkg::word_t byte_mask(input logic [3:0] we);
		mips_pkg::word_t m;
		for (int b = 0; b < 4; b++)
			m[8*b +: 8] = {8{we[b]}};
		return m;
	endfunction

	task automatic load_cases;
		int fd;
		int code;
		string line;
		string rest;
		string name;
		logic [7:0] kind;
		mips_pkg::word_t a;
		mips_pkg::word_t b;
		mips_pkg::word_t c;
		for (int i = 0; i < 256; i++)
			imem[i] = mips_pkg::nop_word;
		for (int i = 0; i < 1024; i++)
			dmem[i] <= 32'h5A5A_0000 ^ (i << 2);   // unwritten words show their own address
		fd = $fopen(cases_path, "r");
		if (fd == 0)
			fail_run("cannot open the cases file");
		n_prog = 0;
		n_exp = 0;
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code > 1 && line.getc(0) != "#") begin
				kind = line.getc(0);
				rest = line.substr(1, line.len() - 1);
				if (kind == "p") begin
					if ($sscanf(rest, "%h %h", a, b) != 2)
						fail_run("bad program line in the cases file");
					imem[a[7:0]] = b;
					if (int'(a) + 1 > n_prog)
						n_prog = int'(a) + 1;
				end else if (kind == "d") begin
					if ($sscanf(rest, "%h %h", a, b) != 2)
						fail_run("bad data line in the cases file");
					dmem[a[11:2]] <= b;
				end else if (kind == "s") begin
					if (n_exp >= max_stores || $sscanf(rest, "%s %h %h %h", name, a, b, c) != 4)
						fail_run("bad or too many store lines in the cases file");
					exp_name[n_exp] = name;
					exp_addr[n_exp] = a;
					exp_data[n_exp] = b;
					exp_we[n_exp] = c[3:0];
					n_exp++;
				end else begin
					fail_run("unknown line kind in the cases file");
				end
			end
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////
	// clock, reset and run control
	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		loaded = 1'b0;
		n_seen = 0;
		reset_edges = 0;
		load_cases();
		loaded = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#1;
		rst = 1'b0;
		while (!(n_seen == n_exp && self_loop))
			@(negedge clk);
		repeat (8) @(negedge clk);   // let the pipeline drain
		if (n_seen == n_exp && self_loop) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			fail_run("program left its final loop");
		end
	end

	// watchdog, sized from the program length
	initial begin
		int limit_ns;
		wait (loaded);
		limit_ns = (reset_cycles + 20 * n_prog + 200) * clk_period;
		#(limit_ns);
		fail_run($sformatf("timeout with %0d of %0d expected stores seen", n_seen, n_exp));
	end

	////////////////////////////////////////////////////////////
	// store checker and data memory write
	always @(posedge clk) begin
		if (rst) begin
			if (reset_edges > 0)   // first edge still sees unreset stage registers
				check_value("reset_idle", "strobes", 32'd0, {27'd0, mem_rd, mem_we});
			reset_edges = reset_edges + 1;
		end else if (mem_we != 4'b0000) begin
			if (n_seen >= n_exp)
				fail_run("store seen beyond the expected list");
			check_value(exp_name[n_seen], "address", exp_addr[n_seen], mem_addr);
			check_value(exp_name[n_seen], "data", exp_data[n_seen] & byte_mask(exp_we[n_seen]),
				mem_data & byte_mask(exp_we[n_seen]));
			check_value(exp_name[n_seen], "enables", {28'd0, exp_we[n_seen]}, {28'd0, mem_we});
			for (int b = 0; b < 4; b++)
				if (mem_we[b])
					dmem[mem_addr[11:2]][8*b +: 8] <= mem_data[8*b +: 8];
			n_seen = n_seen + 1;
		end
	end

endmodule

`default_nettype wire

// ==== test/cpu_cases.txt ====
# p <word index> <instruction>         d <byte address> <word>
# s <test name> <address> <lane-placed data> <byte enables>    all numbers hex
p 00 3C018000  lui   $1, 0x8000
p 01 2422FFFF  addiu $2, $1, -1
p 02 00411821  addu  $3, $2, $1
p 03 24640002  addiu $4, $3, 2
p 04 AC040400  sw    $4, 0x400($0)
p 05 00232823  subu  $5, $1, $3
p 06 AC050404  sw    $5, 0x404($0)
p 07 0022302A  slt   $6, $1, $2
p 08 0022382B  sltu  $7, $1, $2
p 09 AC060408  sw    $6, 0x408($0)
p 0A AC07040C  sw    $7, 0x40C($0)
p 0B 30688F0F  andi  $8, $3, 0x8F0F
p 0C 3429F00F  ori   $9, $1, 0xF00F
p 0D 392AFFFF  xori  $10, $9, 0xFFFF
p 0E 01485827  nor   $11, $10, $8
p 0F 01696024  and   $12, $11, $9
p 10 018A6826  xor   $13, $12, $10
p 11 01A87025  or    $14, $13, $8
p 12 282FFFFF  slti  $15, $1, -1
p 13 AC080410  sw    $8, 0x410($0)
p 14 AC0A0414  sw    $10, 0x414($0)
p 15 AC0B0418  sw    $11, 0x418($0)
p 16 AC0E041C  sw    $14, 0x41C($0)
p 17 AC0F0420  sw    $15, 0x420($0)
p 18 8C100200  lw    $16, 0x200($0)
p 19 26110001  addiu $17, $16, 1
p 1A AC110424  sw    $17, 0x424($0)
p 1B 80120200  lb    $18, 0x200($0)
p 1C 80130201  lb    $19, 0x201($0)
p 1D 80140202  lb    $20, 0x202($0)
p 1E 80150203  lb    $21, 0x203($0)
p 1F 90160200  lbu   $22, 0x200($0)
p 20 90170201  lbu   $23, 0x201($0)
p 21 90180202  lbu   $24, 0x202($0)
p 22 90190203  lbu   $25, 0x203($0)
p 23 AC190444  sw    $25, 0x444($0)
p 24 AC120428  sw    $18, 0x428($0)
p 25 AC13042C  sw    $19, 0x42C($0)
p 26 AC140430  sw    $20, 0x430($0)
p 27 AC150434  sw    $21, 0x434($0)
p 28 AC160438  sw    $22, 0x438($0)
p 29 AC17043C  sw    $23, 0x43C($0)
p 2A AC180440  sw    $24, 0x440($0)
p 2B A0050450  sb    $5, 0x450($0)
p 2C A0100455  sb    $16, 0x455($0)
p 2D A011045A  sb    $17, 0x45A($0)
p 2E A004045F  sb    $4, 0x45F($0)
p 2F AC040461  sw    $4, 0x461($0)   unaligned
p 30 10840002  beq   $4, $4, +2
p 31 AC040470  sw    $4, 0x470($0)   delay slot
p 32 AC0404F0  sw    $4, 0x4F0($0)   skipped
p 33 1484FFFE  bne   $4, $4, -2
p 34 AC040474  sw    $4, 0x474($0)   delay slot
p 35 AC040478  sw    $4, 0x478($0)
p 36 14810002  bne   $4, $1, +2
p 37 AC04047C  sw    $4, 0x47C($0)   delay slot
p 38 AC0404F4  sw    $4, 0x4F4($0)   skipped
p 39 1081FFFE  beq   $4, $1, -2
p 3A AC040480  sw    $4, 0x480($0)   delay slot
p 3B 0C000041  jal   0x104
p 3C AC040484  sw    $4, 0x484($0)   delay slot
p 3D AC1F0488  sw    $31, 0x488($0)
p 3E 08000043  j     0x10C
p 3F AC04048C  sw    $4, 0x48C($0)   delay slot
p 40 AC0404F8  sw    $4, 0x4F8($0)   skipped
p 41 03E00008  jr    $31
p 42 AC040490  sw    $4, 0x490($0)   delay slot
p 43 08000043  j     0x10C           final loop
p 44 00000000  nop
d 200 8A9C35F3
s addiu_wrap 400 00000001 f
s subu_wrap 404 80000001 f
s slt_signed 408 00000001 f
s sltu_unsigned 40C 00000000 f
s andi_zext 410 00008F0F f
s ori_xori 414 80000FF0 f
s nor 418 7FFF7000 f
s and_xor_or 41C 8000FFFF f
s slti 420 00000001 f
s lw_use 424 8A9C35F4 f
s lbu_lane3 444 0000008A f
s lb_lane0 428 FFFFFFF3 f
s lb_lane1 42C 00000035 f
s lb_lane2 430 FFFFFF9C f
s lb_lane3 434 FFFFFF8A f
s lbu_lane0 438 000000F3 f
s lbu_lane1 43C 00000035 f
s lbu_lane2 440 0000009C f
s sb_lane0 450 00000001 1
s sb_lane1 454 0000F300 2
s sb_lane2 458 00F40000 4
s sb_lane3 45C 01000000 8
s beq_delay 470 00000001 f
s bne_delay_nt 474 00000001 f
s bne_fall 478 00000001 f
s bne_delay 47C 00000001 f
s beq_delay_nt 480 00000001 f
s jal_delay 484 00000001 f
s jr_delay 490 00000001 f
s jal_link 488 000000F4 f
s j_delay 48C 00000001 f

// ==== pipeline_cpu.f ====
logic/mips_pkg.sv
logic/mips_decoder.sv
logic/reg_file.sv
logic/operand_forward.sv
logic/alu.sv
logic/mem_lanes.sv
logic/pipeline_cpu.sv
test/cpu_tb.sv

// ==== Makefile ====
# Verilator build and run for the pipelined MIPS core

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= pipeline_cpu.f
BUILD_DIR ?= obj_dir
CASES     ?= test/cpu_cases.txt
VFLAGS    ?= --binary --timing --timescale 1ns/10ps

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM) $(CASES)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
